// ==== hdl/rob_pkg.sv ====
// ======================================================================
// Reorder buffer package: shared widths, trap info and write-back word
// ======================================================================

package rob_pkg;

    localparam int pc_w    = 32;  // program counter
    localparam int data_w  = 32;  // write-back payload
    localparam int cause_w = 8;   // exception cause code
    localparam int tval_w  = 24;  // trap value, fills the rest of the word

    // trap view of a payload word
    typedef struct packed {
        logic [cause_w-1:0] cause;  // upper byte
        logic [tval_w-1:0]  tval;   // lower bits
    } trap_info_t;

    // one write-back word, decoded by the exception flag
    typedef union packed {
        logic [data_w-1:0] result;  // normal instruction result
        trap_info_t        trap;    // excepting instruction
    } exe_payload_u;

endpackage

// ==== hdl/rob_front_if.sv ====
// ======================================================================
// Front view of the reorder buffer: oldest entries out, commit decision back
// ======================================================================

interface rob_front_if #(
    parameter int depth     = 8,
    parameter int com_width = 2
);

    localparam int idx_w = $clog2(depth);
    localparam int cnt_w = $clog2(depth) + 1;
    localparam int ret_w = $clog2(com_width + 1);

    // slot i is the entry at head plus i
    logic [cnt_w-1:0]                        count;     // live entries
    logic [idx_w-1:0]                        front_id;  // head index
    logic [com_width-1:0]                    done;      // written back
    logic [com_width-1:0]                    exc;       // written back with exception
    logic [com_width-1:0][rob_pkg::pc_w-1:0] pc;
    rob_pkg::exe_payload_u [com_width-1:0]   payload;

    logic [ret_w-1:0] retire;  // entries leaving this cycle
    logic             flush;   // precise exception at head

    modport queue (
        output count, front_id, done, exc, pc, payload,
        input  retire, flush
    );

    modport commit (
        input  count, front_id, done, exc, pc, payload,
        output retire, flush
    );

endinterface

// ==== hdl/rob_entry_ram.sv ====
// ======================================================================
// Entry storage: one clocked write port, com_width combinational reads
// ======================================================================

module rob_entry_ram #(
    parameter int width     = 32,
    parameter int depth     = 8,
    parameter int com_width = 2
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 wr_en,
    input  logic [$clog2(depth)-1:0]             wr_addr,
    input  logic [width-1:0]                     wr_data,
    input  logic [com_width-1:0][$clog2(depth)-1:0] rd_addr,
    output logic [com_width-1:0][width-1:0]      rd_data
);

    logic [width-1:0] mem [depth];

    // writes held off during reset
    always_ff @(posedge clk) begin
        if (wr_en && !rst) begin
            mem[wr_addr] <= wr_data;
        end
    end

    always_comb begin
        for (int i = 0; i < com_width; i++) begin
            rd_data[i] = mem[rd_addr[i]];  // async read per slot
        end
    end

endmodule

// ==== hdl/rob_queue.sv ====
// ======================================================================
// Reorder buffer queue: pointers, entry status bits and entry storage,
// presenting the oldest com_width entries to the commit stage
// ======================================================================

module rob_queue #(
    parameter int depth     = 8,
    parameter int com_width = 2
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         alloc_valid,
    input  logic [rob_pkg::pc_w-1:0]     alloc_pc,
    output logic                         alloc_ready,
    output logic [$clog2(depth)-1:0]     alloc_id,
    input  logic                         exe_valid,
    input  logic [$clog2(depth)-1:0]     exe_id,
    input  logic                         exe_exc,
    input  rob_pkg::exe_payload_u        exe_payload,
    rob_front_if.queue                   front
);

    localparam int idx_w = $clog2(depth);
    localparam int cnt_w = $clog2(depth) + 1;

    logic [idx_w-1:0]                  head;
    logic [idx_w-1:0]                  tail;
    logic [cnt_w-1:0]                  count;
    logic [depth-1:0]                  done_q;
    logic [depth-1:0]                  exc_q;
    logic [com_width-1:0][idx_w-1:0]   rd_addr;
    logic                              alloc_fire;

    assign alloc_ready = (count != cnt_w'(depth)) && !front.flush;
    assign alloc_fire  = alloc_valid && alloc_ready;
    assign alloc_id    = tail;

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (front.flush) begin
            tail  <= head;  // head stays on the excepting entry
            count <= '0;
        end else begin
            head  <= head + idx_w'(front.retire);
            tail  <= tail + idx_w'(alloc_fire);
            count <= count + cnt_w'(alloc_fire) - cnt_w'(front.retire);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            done_q <= '0;
            exc_q  <= '0;
        end else begin
            if (alloc_fire) begin
                done_q[tail] <= 1'b0;  // fresh entry
                exc_q[tail]  <= 1'b0;
            end
            if (exe_valid) begin
                done_q[exe_id] <= 1'b1;
                exc_q[exe_id]  <= exe_exc;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < com_width; i++) begin
            rd_addr[i]    = head + idx_w'(i);
            front.done[i] = done_q[rd_addr[i]];
            front.exc[i]  = exc_q[rd_addr[i]];
        end
    end

    assign front.count    = count;
    assign front.front_id = head;

    rob_entry_ram #(
        .width     (rob_pkg::pc_w),
        .depth     (depth),
        .com_width (com_width)
    ) pc_ram_i (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (alloc_fire),  // pc written at allocation
        .wr_addr (tail),
        .wr_data (alloc_pc),
        .rd_addr (rd_addr),
        .rd_data (front.pc)
    );

    rob_entry_ram #(
        .width     (rob_pkg::data_w),
        .depth     (depth),
        .com_width (com_width)
    ) payload_ram_i (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (exe_valid),   // payload written at write-back
        .wr_addr (exe_id),
        .wr_data (exe_payload),
        .rd_addr (rd_addr),
        .rd_data (front.payload)
    );

endmodule

// ==== hdl/rob_commit.sv ====
// ======================================================================
// Commit stage: in-order retirement of done entries, precise exception
// ======================================================================

module rob_commit #(
    parameter int depth     = 8,
    parameter int com_width = 2
) (
    rob_front_if.commit                           front,
    input  logic [rob_pkg::pc_w-1:0]              tvec,
    output logic [com_width-1:0]                  com_valid,
    output logic [com_width-1:0][rob_pkg::pc_w-1:0]   com_pc,
    output logic [com_width-1:0][rob_pkg::data_w-1:0] com_data,
    output logic                                  exception,
    output logic [rob_pkg::pc_w-1:0]              epc,
    output logic [rob_pkg::cause_w-1:0]           cause,
    output logic [rob_pkg::tval_w-1:0]            tval,
    output logic [rob_pkg::pc_w-1:0]              redirect_pc
);

    localparam int cnt_w = $clog2(depth) + 1;
    localparam int ret_w = $clog2(com_width + 1);

    logic [com_width-1:0] live;      // slot within count
    logic [com_width-1:0] slot_ok;   // slot could leave on its own
    logic [com_width:0]   chain;     // all older slots leave too
    logic [ret_w-1:0]     n_retire;
    logic                 head_trap;

    always_comb begin
        for (int i = 0; i < com_width; i++) begin
            live[i]    = cnt_w'(i) < front.count;
            slot_ok[i] = live[i] && front.done[i] && !front.exc[i];
        end
    end

    // a trap at slot 0 clears slot_ok[0] and so blocks every slot
    always_comb begin
        chain[0] = 1'b1;
        for (int i = 0; i < com_width; i++) begin
            chain[i+1]   = chain[i] && slot_ok[i];
            com_valid[i] = chain[i+1];
            com_pc[i]    = front.pc[i];
            com_data[i]  = front.payload[i].result;
        end
    end

    always_comb begin
        n_retire = '0;
        for (int i = 0; i < com_width; i++) begin
            n_retire = n_retire + ret_w'(com_valid[i]);
        end
    end

    assign head_trap = live[0] && front.done[0] && front.exc[0];

    assign exception   = head_trap;  // count drops to zero after flush
    assign epc         = front.pc[0];
    assign cause       = front.payload[0].trap.cause;
    assign tval        = front.payload[0].trap.tval;
    assign redirect_pc = tvec;

    assign front.retire = n_retire;
    assign front.flush  = head_trap;

endmodule

// ==== hdl/rob_top.sv ====
// ======================================================================
// Reorder buffer top: queue and commit stage joined by the front view
// ======================================================================

module rob_top #(
    parameter int depth     = 8,
    parameter int com_width = 2
) (
    input  logic                                      clk,
    input  logic                                      rst,
    // allocation, valid/ready
    input  logic                                      alloc_valid,
    input  logic [rob_pkg::pc_w-1:0]                  alloc_pc,
    output logic                                      alloc_ready,
    output logic [$clog2(depth)-1:0]                  alloc_id,
    // execution write-back
    input  logic                                      exe_valid,
    input  logic [$clog2(depth)-1:0]                  exe_id,
    input  logic                                      exe_exc,
    input  logic [rob_pkg::data_w-1:0]                exe_payload,
    // commit
    output logic [com_width-1:0]                      com_valid,
    output logic [com_width-1:0][rob_pkg::pc_w-1:0]   com_pc,
    output logic [com_width-1:0][rob_pkg::data_w-1:0] com_data,
    // exception
    input  logic [rob_pkg::pc_w-1:0]                  tvec,
    output logic                                      exception,
    output logic [rob_pkg::pc_w-1:0]                  epc,
    output logic [rob_pkg::cause_w-1:0]               cause,
    output logic [rob_pkg::tval_w-1:0]                tval,
    output logic [rob_pkg::pc_w-1:0]                  redirect_pc
);

    rob_front_if #(
        .depth     (depth),
        .com_width (com_width)
    ) front_i ();

    rob_queue #(
        .depth     (depth),
        .com_width (com_width)
    ) rob_queue_i (
        .clk         (clk),
        .rst         (rst),
        .alloc_valid (alloc_valid),
        .alloc_pc    (alloc_pc),
        .alloc_ready (alloc_ready),
        .alloc_id    (alloc_id),
        .exe_valid   (exe_valid),
        .exe_id      (exe_id),
        .exe_exc     (exe_exc),
        .exe_payload (exe_payload),
        .front       (front_i.queue)
    );

    rob_commit #(
        .depth     (depth),
        .com_width (com_width)
    ) rob_commit_i (
        .front       (front_i.commit),
        .tvec        (tvec),
        .com_valid   (com_valid),
        .com_pc      (com_pc),
        .com_data    (com_data),
        .exception   (exception),
        .epc         (epc),
        .cause       (cause),
        .tval        (tval),
        .redirect_pc (redirect_pc)
    );

endmodule

// ==== tests/rob_props.sv ====
// ======================================================================
// Reorder buffer checks: commit slot order, exception and allocation
// ======================================================================

module rob_props #(
    parameter int com_width = 2
) (
    input logic                 clk,
    input logic                 rst,
    input logic [com_width-1:0] com_valid,
    input logic                 exception,
    input logic                 alloc_ready
);
    timeunit 1ns;
    timeprecision 100ps;

    // slots retire strictly from the head
    slot_order: assert property (@(posedge clk) disable iff (rst)
        com_valid[1] |-> com_valid[0])
        else $error("commit slot 1 valid without slot 0");

    // a trapping head blocks every commit
    trap_no_commit: assert property (@(posedge clk) disable iff (rst)
        exception |-> (com_valid == '0))
        else $error("commit together with an exception");

    trap_stalls_alloc: assert property (@(posedge clk) disable iff (rst)
        exception |-> !alloc_ready)
        else $error("allocation open during an exception");

endmodule

bind rob_top rob_props #(.com_width(com_width)) rob_props_i (
    .clk         (clk),
    .rst         (rst),
    .com_valid   (com_valid),
    .exception   (exception),
    .alloc_ready (alloc_ready)
);

// ==== tests/rob_tb.sv ====
// ======================================================================
// Reorder buffer testbench: directed tests against an in-order model
// ======================================================================

module rob_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int depth       = 8;
    localparam int com_width   = 2;
    localparam int wait_limit  = 200;  // cycles per wait
    localparam logic [rob_pkg::pc_w-1:0] trap_vector = 32'h0000_0100;

    logic clk;
    logic rst;
    logic alloc_valid;
    logic [rob_pkg::pc_w-1:0] alloc_pc;
    logic alloc_ready;
    logic [2:0] alloc_id;
    logic exe_valid;
    logic [2:0] exe_id;
    logic exe_exc;
    logic [rob_pkg::data_w-1:0] exe_payload;
    logic [com_width-1:0] com_valid;
    logic [com_width-1:0][rob_pkg::pc_w-1:0] com_pc;
    logic [com_width-1:0][rob_pkg::data_w-1:0] com_data;
    logic [rob_pkg::pc_w-1:0] tvec;
    logic exception;
    logic [rob_pkg::pc_w-1:0] epc;
    logic [rob_pkg::cause_w-1:0] cause;
    logic [rob_pkg::tval_w-1:0] tval;
    logic [rob_pkg::pc_w-1:0] redirect_pc;

    int seed = 32'h5073;
    logic [rob_pkg::pc_w-1:0] ref_pc [depth];    // model state per entry id
    logic [rob_pkg::data_w-1:0] ref_data [depth];
    logic ref_done [depth];
    logic ref_exc [depth];
    logic [2:0] ref_order [$];      // live ids, oldest first
    logic [2:0] next_id = '0;       // model tail
    int committed = 0;
    int exc_count = 0;

    rob_top #(
        .depth     (depth),
        .com_width (com_width)
    ) rob_top_i (
        .clk (clk), .rst (rst),
        .alloc_valid (alloc_valid), .alloc_pc (alloc_pc),
        .alloc_ready (alloc_ready), .alloc_id (alloc_id),
        .exe_valid (exe_valid), .exe_id (exe_id),
        .exe_exc (exe_exc), .exe_payload (exe_payload),
        .com_valid (com_valid), .com_pc (com_pc), .com_data (com_data),
        .tvec (tvec), .exception (exception), .epc (epc),
        .cause (cause), .tval (tval), .redirect_pc (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("ERROR at %0t ns: %s is 0x%h, expected 0x%h",
                               $time, what, got, exp));
        end
    endtask

    // commit monitor, pops the model in program order
    always @(posedge clk) begin : commit_monitor
        logic [2:0] id;
        if (!rst) begin
            for (int s = 1; s < com_width; s++) begin
                if (com_valid[s] && !com_valid[0]) begin
                    fail_run("a commit slot was valid while slot 0 was not");
                end
            end
            if (exception && com_valid != '0) begin
                fail_run("a commit came together with an exception");
            end
            if (exception && alloc_ready) begin
                fail_run("alloc_ready was high during an exception");
            end
            for (int s = 0; s < com_width; s++) begin
                if (com_valid[s]) begin
                    if (ref_order.size() == 0) begin
                        fail_run("a commit appeared with no live entry in the model");
                    end
                    id = ref_order.pop_front();
                    check_value("committed entry done", ref_done[id], 1'b1);
                    check_value("committed entry exception", ref_exc[id], 1'b0);
                    check_value("com_pc", com_pc[s], ref_pc[id]);
                    check_value("com_data", com_data[s], ref_data[id]);
                    committed++;
                end
            end
            if (exception) begin
                if (ref_order.size() == 0) begin
                    fail_run("an exception appeared with no live entry in the model");
                end
                id = ref_order[0];
                check_value("head exception flag", ref_exc[id], 1'b1);
                check_value("epc", epc, ref_pc[id]);
                check_value("cause", cause, ref_data[id][31:24]);  // trap view, upper byte
                check_value("tval", tval, ref_data[id][23:0]);
                check_value("redirect_pc", redirect_pc, trap_vector);
                exc_count++;
                next_id = id;        // tail returns to the excepting entry
                ref_order.delete();  // whole buffer flushed
            end
        end
    end

    // called at a falling edge, returns at a falling edge
    task automatic alloc_entry(input logic [rob_pkg::pc_w-1:0] pc, output logic [2:0] id);
        int waited;
        alloc_valid = 1'b1;
        alloc_pc = pc;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (!alloc_ready && waited > wait_limit) begin
                fail_run("timed out waiting for alloc_ready during an allocation");
            end
        end while (!alloc_ready);
        check_value("alloc_id", alloc_id, next_id);
        id = next_id;
        next_id++;
        ref_pc[id] = pc;
        ref_done[id] = 1'b0;
        ref_exc[id] = 1'b0;
        ref_order.push_back(id);
        @(negedge clk);
        alloc_valid = 1'b0;
    endtask

    task automatic write_back(input logic [2:0] id, input logic exc, input logic [31:0] data);
        exe_valid = 1'b1;
        exe_id = id;
        exe_exc = exc;
        exe_payload = data;
        ref_data[id] = data;
        ref_exc[id] = exc;
        ref_done[id] = 1'b1;
        @(negedge clk);
        exe_valid = 1'b0;
        exe_exc = 1'b0;
    endtask

    task automatic wait_commits(input int target);
        int waited;
        waited = 0;
        while (committed < target) begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit) begin
                fail_run($sformatf("timed out waiting for commit number %0d", target));
            end
        end
    endtask

    task automatic wait_exception(input int target);
        int waited;
        waited = 0;
        while (exc_count < target) begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit) begin
                fail_run("timed out waiting for the exception pulse");
            end
        end
    endtask

    task automatic wait_alloc_ready();
        int waited;
        waited = 0;
        while (!alloc_ready) begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit) begin
                fail_run("timed out waiting for alloc_ready to rise again");
            end
        end
    endtask

    task automatic reset_values();
        check_value("com_valid after reset", com_valid, '0);
        check_value("exception after reset", exception, 1'b0);
        check_value("alloc_ready after reset", alloc_ready, 1'b1);
        check_value("alloc_id after reset", alloc_id, '0);
    endtask

    task automatic in_order_commit();
        logic [2:0] ids [4];
        int base_com;
        base_com = committed;
        for (int i = 0; i < 4; i++) begin
            alloc_entry(32'h1000 + 32'(4 * i), ids[i]);
        end
        write_back(ids[3], 1'b0, $random(seed));
        write_back(ids[1], 1'b0, $random(seed));
        @(negedge clk);  // room for a wrong early commit
        check_value("commits before entry 0 is done", committed, base_com);
        write_back(ids[0], 1'b0, $random(seed));
        write_back(ids[2], 1'b0, $random(seed));
        wait_commits(base_com + 4);
        check_value("live entries after in-order test", ref_order.size(), 0);
    endtask

    task automatic full_backpressure();
        logic [2:0] ids [depth+1];
        int n;
        int base_com;
        base_com = committed;
        n = 0;
        while (alloc_ready && n <= depth) begin
            alloc_entry(32'h2000 + 32'(4 * n), ids[n]);
            n++;
        end
        check_value("allocations until full", n, depth);
        check_value("commits while filling", committed, base_com);
        write_back(ids[0], 1'b0, $random(seed));
        wait_alloc_ready();
        check_value("commits after head write-back", committed, base_com + 1);
        for (int i = 1; i < depth; i++) begin
            write_back(ids[i], 1'b0, $random(seed));
        end
        wait_commits(base_com + depth);
    endtask

    task automatic precise_exception();
        logic [2:0] ids [5];
        int base_com;
        int base_exc;
        base_com = committed;
        base_exc = exc_count;
        for (int i = 0; i < 5; i++) begin
            alloc_entry(32'h3000 + 32'(4 * i), ids[i]);
        end
        write_back(ids[3], 1'b0, $random(seed));
        write_back(ids[0], 1'b0, $random(seed));
        write_back(ids[1], 1'b0, $random(seed));
        write_back(ids[4], 1'b0, $random(seed));
        write_back(ids[2], 1'b1, $random(seed));
        wait_exception(base_exc + 1);
        check_value("commits before the exception", committed, base_com + 2);
        repeat (4) @(negedge clk);  // watch for a second pulse or late commits
        check_value("exception pulses", exc_count, base_exc + 1);
        check_value("commits after flush", committed, base_com + 2);
        check_value("alloc_id after flush", alloc_id, ids[2]);
    endtask

    task automatic random_stream();
        int pend[$];
        int issued;
        int steps;
        int pick;
        int base_com;
        logic [2:0] id;
        base_com = committed;
        issued = 0;
        steps = 0;
        while (issued < 200 || pend.size() > 0) begin
            pick = $unsigned($random(seed)) % 4;
            steps++;
            if (steps > 5000) begin
                fail_run("random stream stopped making progress");
            end
            if (pend.size() > 0 && (pick == 0 || issued == 200 || !alloc_ready)) begin
                pick = $unsigned($random(seed)) % pend.size();
                write_back(pend[pick], 1'b0, $random(seed));
                pend.delete(pick);
            end else if (issued < 200 && alloc_ready && pick != 3) begin
                alloc_entry(32'h8000_0000 + 32'(4 * issued), id);
                pend.push_back(id);
                issued++;
            end else begin
                @(negedge clk);  // allocation gap
            end
        end
        wait_commits(base_com + 200);
        for (int i = 0; i < depth; i++) begin
            check_value("alloc_ready on drained buffer", alloc_ready, 1'b1);
            alloc_entry(32'h9000 + 32'(4 * i), id);
        end
    endtask

    initial begin
        rst = 1'b1;
        alloc_valid = 1'b0;
        alloc_pc = '0;
        exe_valid = 1'b0;
        exe_id = '0;
        exe_exc = 1'b0;
        exe_payload = '0;
        tvec = trap_vector;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        reset_values();
        in_order_commit();
        full_backpressure();
        precise_exception();
        random_stream();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== src.f ====
hdl/rob_pkg.sv
hdl/rob_front_if.sv
hdl/rob_entry_ram.sv
hdl/rob_queue.sv
hdl/rob_commit.sv
hdl/rob_top.sv
tests/rob_props.sv
tests/rob_tb.sv
